/* verilog/ulpiRxPkg.sv */
package ulpiRxPkg;

    // Payloads carried by the two receive buffers
    typedef logic [7:0] usbByteT;

    typedef struct packed {
        logic [5:0] rxEvent;    // Low bits of the last RX command
        logic [9:0] byteCount;  // Data bytes in the burst
    } infoWordT;

    // Buffer geometry
    localparam int fifoDepth = 16;
    localparam int fifoAddrW = $clog2(fifoDepth);

    // APB register map, byte addresses
    localparam logic [3:0] regCtrl   = 4'h0;
    localparam logic [3:0] regStatus = 4'h4;
    localparam logic [3:0] regData   = 4'h8;
    localparam logic [3:0] regInfo   = 4'hC;

    // Control register bits
    localparam int ctrlReadAllow = 0;
    localparam int ctrlClrOvf    = 1;

    // Status word layout
    localparam int statRxCmd      = 0;   // 8 bits wide
    localparam int statLineState  = 8;   // 2 bits wide
    localparam int statVbusState  = 10;  // 2 bits wide
    localparam int statRxActive   = 12;
    localparam int statRxError    = 13;
    localparam int statHostDisc   = 14;
    localparam int statRxId       = 15;
    localparam int statBusy       = 16;
    localparam int statDataEmpty  = 17;
    localparam int statInfoEmpty  = 18;
    localparam int statDataOvf    = 19;
    localparam int statInfoOvf    = 20;

    // RX command event field, bits 5:4
    localparam int         rxActiveBit     = 4;
    localparam logic [1:0] rxEvtDisconnect = 2'b10;
    localparam logic [1:0] rxEvtError      = 2'b11;

endpackage

/* verilog/rxFifoIf.sv */
`timescale 1ns/1ps

// Link between a writer, one buffer and a reader
interface rxFifoIf #(
    parameter type payloadT = ulpiRxPkg::usbByteT
);

    // Write side
    logic    wrValid;   // Writes on every cycle it is high
    payloadT wrData;
    logic    full;

    // Read side
    logic    rdEn;      // Pops the head entry
    payloadT rdData;    // Head entry, always visible
    logic    empty;

    modport producer (
        output wrValid,
        output wrData,
        input  full
    );

    modport bufferWr (
        input  wrValid,
        input  wrData,
        output full
    );

    modport bufferRd (
        input  rdEn,
        output rdData,
        output empty
    );

    modport consumer (
        output rdEn,
        input  rdData,
        input  empty
    );

endinterface

/* verilog/ulpiRecv.sv */
`timescale 1ns/1ps

module ulpiRecv (
    input  logic                clkUlpi,
    input  logic                rst,
    input  logic                dir,
    input  logic                nxt,
    input  ulpiRxPkg::usbByteT  dataI,
    input  logic                readAllow,
    input  logic                clrOverflow,
    rxFifoIf.producer           dataOut,
    rxFifoIf.producer           infoOut,
    output logic [7:0]          rxCmd,
    output logic                busy,
    output logic                dataOverflow,
    output logic                infoOverflow
);

    import ulpiRxPkg::*;

    typedef enum logic {
        stIdle,
        stRead
    } stateT;

    stateT    state;
    logic     dirQ;         // dir from the previous edge
    logic     startBurst;
    logic     active;
    logic     cmdHit;
    logic     dataHit;
    logic     dataPend;     // Byte waiting to be written
    logic     infoPend;     // Info word waiting to be written
    usbByteT  dataByte;
    logic [9:0] byteCount;
    infoWordT infoWord;

    // A burst opens only on the rising edge of dir
    assign startBurst = (state == stIdle) && dir && !dirQ && readAllow;
    assign active     = (state == stRead) || startBurst;

    assign cmdHit  = dir && !nxt;
    assign dataHit = dir && nxt && active;

    assign busy = (state == stRead);

    always_ff @(posedge clkUlpi) begin
        if (!rst) begin
            state <= stIdle;
            dirQ  <= 1'b0;
        end else begin
            dirQ <= dir;
            case (state)
                stIdle: if (startBurst) state <= stRead;
                stRead: if (!dir) state <= stIdle;
                default: state <= stIdle;
            endcase
        end
    end

    // RX command register, shown in the status word
    always_ff @(posedge clkUlpi) begin
        if (!rst) begin
            rxCmd <= '0;
        end else if (cmdHit) begin
            rxCmd <= dataI;
        end
    end

    always_ff @(posedge clkUlpi) begin
        if (dir && nxt) begin
            dataByte <= dataI;
        end
    end

    // Counts on, even while bytes are dropped
    always_ff @(posedge clkUlpi) begin
        if (!rst) begin
            byteCount <= '0;
        end else if (dataHit) begin
            byteCount <= (state == stIdle) ? 10'd1 : byteCount + 10'd1;
        end else if (state == stIdle) begin
            byteCount <= '0;
        end
    end

    always_ff @(posedge clkUlpi) begin
        if (!rst) begin
            dataPend <= 1'b0;
            infoPend <= 1'b0;
        end else begin
            dataPend <= dataHit;
            infoPend <= (state == stRead) && !dir;  // Burst end
        end
    end

    // Count and command are still stable in the cycle after the burst end
    assign infoWord.rxEvent   = rxCmd[5:0];
    assign infoWord.byteCount = byteCount;

    assign dataOut.wrValid = dataPend && !dataOut.full;
    assign dataOut.wrData  = dataByte;
    assign infoOut.wrValid = infoPend && !infoOut.full;
    assign infoOut.wrData  = infoWord;

    // Sticky drop flags, a new drop wins over a clear
    always_ff @(posedge clkUlpi) begin
        if (!rst) begin
            dataOverflow <= 1'b0;
        end else if (dataPend && dataOut.full) begin
            dataOverflow <= 1'b1;
        end else if (clrOverflow) begin
            dataOverflow <= 1'b0;
        end
    end

    always_ff @(posedge clkUlpi) begin
        if (!rst) begin
            infoOverflow <= 1'b0;
        end else if (infoPend && infoOut.full) begin
            infoOverflow <= 1'b1;
        end else if (clrOverflow) begin
            infoOverflow <= 1'b0;
        end
    end

endmodule

/* verilog/rxFifo.sv */
`timescale 1ns/1ps

module rxFifo #(
    parameter type payloadT = ulpiRxPkg::usbByteT
) (
    input  logic       clkUlpi,
    input  logic       rst,
    rxFifoIf.bufferWr  wr,
    rxFifoIf.bufferRd  rd
);

    import ulpiRxPkg::*;

    payloadT mem [fifoDepth];

    logic [fifoAddrW-1:0] wrPtr;
    logic [fifoAddrW-1:0] rdPtr;
    logic [fifoAddrW:0]   count;   // Occupancy
    logic                 doWr;
    logic                 doRd;

    assign doWr = wr.wrValid;   // Writer never writes when full
    assign doRd = rd.rdEn;      // Reader never pops when empty

    assign wr.full  = (count == (fifoAddrW + 1)'(fifoDepth));
    assign rd.empty = (count == '0);

    // First word fall through
    assign rd.rdData = mem[rdPtr];

    function automatic logic [fifoAddrW-1:0] nextPtr(input logic [fifoAddrW-1:0] ptr);
        logic [fifoAddrW-1:0] last;
        last = fifoAddrW'(fifoDepth - 1);
        return (ptr == last) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clkUlpi) begin
        if (doWr) begin
            mem[wrPtr] <= wr.wrData;
        end
    end

    always_ff @(posedge clkUlpi) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doWr) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doRd) begin
                rdPtr <= nextPtr(rdPtr);
            end
        end
    end

    always_ff @(posedge clkUlpi) begin
        if (!rst) begin
            count <= '0;
        end else begin
            case ({doWr, doRd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle, or push and pop together
            endcase
        end
    end

endmodule

/* verilog/apbRxRegs.sv */
`timescale 1ns/1ps

module apbRxRegs (
    input  logic        clkUlpi,
    input  logic        rst,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    rxFifoIf.consumer   dataIn,
    rxFifoIf.consumer   infoIn,
    input  logic [7:0]  rxCmd,
    input  logic        busy,
    input  logic        dataOverflow,
    input  logic        infoOverflow,
    output logic        readAllow,
    output logic        clrOverflow
);

    import ulpiRxPkg::*;

    logic        access;
    logic        writeAcc;
    logic        readAcc;
    logic        dataRead;
    logic        infoRead;
    logic [1:0]  rxEvent;
    logic [31:0] status;
    logic [31:0] readMux;

    // Access phase only, no wait states
    assign access   = psel && penable;
    assign writeAcc = access && pwrite;
    assign readAcc  = access && !pwrite;

    assign dataRead = readAcc && (paddr == regData);
    assign infoRead = readAcc && (paddr == regInfo);

    assign pready = 1'b1;

    // Reading an empty buffer errors out and pops nothing
    assign pslverr = (dataRead && dataIn.empty) || (infoRead && infoIn.empty);

    // Pop lands on the edge closing the access phase
    assign dataIn.rdEn = dataRead && !dataIn.empty;
    assign infoIn.rdEn = infoRead && !infoIn.empty;

    always_ff @(posedge clkUlpi) begin
        if (!rst) begin
            readAllow   <= 1'b0;
            clrOverflow <= 1'b0;
        end else begin
            clrOverflow <= 1'b0;
            if (writeAcc && (paddr == regCtrl)) begin
                readAllow   <= pwdata[ctrlReadAllow];
                clrOverflow <= pwdata[ctrlClrOvf];
            end
        end
    end

    assign rxEvent = rxCmd[5:4];

    always_comb begin
        status = '0;
        status[statRxCmd +: 8]     = rxCmd;
        status[statLineState +: 2] = rxCmd[1:0];
        status[statVbusState +: 2] = rxCmd[3:2];
        status[statRxActive]       = rxCmd[rxActiveBit];
        status[statRxError]        = (rxEvent == rxEvtError);
        status[statHostDisc]       = (rxEvent == rxEvtDisconnect);
        status[statRxId]           = rxCmd[6];
        status[statBusy]           = busy;
        status[statDataEmpty]      = dataIn.empty;
        status[statInfoEmpty]      = infoIn.empty;
        status[statDataOvf]        = dataOverflow;
        status[statInfoOvf]        = infoOverflow;
    end

    always_comb begin
        readMux = '0;
        case (paddr)
            regCtrl: begin
                readMux[ctrlReadAllow] = readAllow;     // Clear bit reads as zero
            end
            regStatus: begin
                readMux = status;
            end
            regData: begin
                if (!dataIn.empty) begin
                    readMux = {24'b0, dataIn.rdData};
                end
            end
            regInfo: begin
                if (!infoIn.empty) begin
                    readMux = {16'b0, infoIn.rdData};
                end
            end
            default: readMux = '0;
        endcase
    end

    // Bus stays quiet outside read accesses
    assign prdata = readAcc ? readMux : '0;

endmodule

/* verilog/ulpiRxTop.sv */
`timescale 1ns/1ps

module ulpiRxTop (
    input  logic                clkUlpi,
    input  logic                rst,

    // ULPI receive lines
    input  logic                dir,
    input  logic                nxt,
    input  ulpiRxPkg::usbByteT  dataI,

    // APB slave
    input  logic [3:0]          paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr
);

    import ulpiRxPkg::*;

    logic [7:0] rxCmd;
    logic       busy;
    logic       dataOverflow;
    logic       infoOverflow;
    logic       readAllow;
    logic       clrOverflow;

    rxFifoIf #(.payloadT(usbByteT))  dataIf ();
    rxFifoIf #(.payloadT(infoWordT)) infoIf ();

    ulpiRecv u_recv (
        .clkUlpi      (clkUlpi),
        .rst          (rst),
        .dir          (dir),
        .nxt          (nxt),
        .dataI        (dataI),
        .readAllow    (readAllow),
        .clrOverflow  (clrOverflow),
        .dataOut      (dataIf.producer),
        .infoOut      (infoIf.producer),
        .rxCmd        (rxCmd),
        .busy         (busy),
        .dataOverflow (dataOverflow),
        .infoOverflow (infoOverflow)
    );

    // Data bytes
    rxFifo #(.payloadT(usbByteT)) u_dataFifo (
        .clkUlpi (clkUlpi),
        .rst     (rst),
        .wr      (dataIf.bufferWr),
        .rd      (dataIf.bufferRd)
    );

    // One word per burst
    rxFifo #(.payloadT(infoWordT)) u_infoFifo (
        .clkUlpi (clkUlpi),
        .rst     (rst),
        .wr      (infoIf.bufferWr),
        .rd      (infoIf.bufferRd)
    );

    apbRxRegs u_regs (
        .clkUlpi      (clkUlpi),
        .rst          (rst),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .dataIn       (dataIf.consumer),
        .infoIn       (infoIf.consumer),
        .rxCmd        (rxCmd),
        .busy         (busy),
        .dataOverflow (dataOverflow),
        .infoOverflow (infoOverflow),
        .readAllow    (readAllow),
        .clrOverflow  (clrOverflow)
    );

endmodule

/* verification/ulpiRxTests.svh */
task automatic afterResetTest();
    usbByteT     bytes[$];
    logic [31:0] stat;
    logic        err;
    startTest("afterReset");
    apbRead(regStatus, stat, err);
    checkValue("status flags", 32'h0006_0000, stat & 32'h001F_0000);  // Only both empties
    bytes = {8'h11, 8'h22, 8'h33};
    ulpiPacket(8'h1C, bytes);   // readAllow still low
    waitIdle();
    apbRead(regStatus, stat, err);
    checkValue("flags after blocked packet", 32'h0006_0000, stat & 32'h001F_0000);
    endTest();
endtask

task automatic singlePacketTest();
    usbByteT     bytes[$];
    logic [31:0] rd;
    logic        err;
    startTest("singlePacket");
    apbWrite(regCtrl, 32'h1, err);
    bytes = {8'hA5, 8'h3C, 8'h00, 8'hFF, 8'h5A};
    ulpiPacket(8'h1D, bytes);
    waitIdle();
    readBytes(bytes);
    readInfo(6'h1D, 5);
    apbRead(regData, rd, err);
    checkValue("pslverr on empty data read", 1, err);
    checkValue("empty data read value", 0, rd);
    endTest();
endtask

task automatic rxCmdOnlyTest();
    usbByteT     cmds[$];
    logic [31:0] stat;
    logic        err;
    startTest("rxCmdOnly");
    cmds = {8'h00, 8'h1D, 8'h2E, 8'h37, 8'h4B, 8'hD1};   // Every event code
    foreach (cmds[i]) begin
        ulpiRxCmd(cmds[i]);
        ulpiRelease();
        waitIdle();
        apbRead(regStatus, stat, err);
        checkValue($sformatf("decode of 0x%0h", cmds[i]), {16'b0, cmdStatus(cmds[i])},
                   stat & 32'hFFFF);
        readInfo(cmds[i][5:0], 0);
    end
    endTest();
endtask

task automatic cmdInPacketTest();
    usbByteT bytes[$];
    startTest("cmdInPacket");
    bytes = {8'h81, 8'h42, 8'hC3, 8'h24};
    ulpiRxCmd(8'h14);
    ulpiByte(bytes[0]);
    ulpiByte(bytes[1]);
    ulpiRxCmd(8'h15);
    ulpiByte(bytes[2]);
    ulpiRxCmd(8'h2B);   // Last command of the burst
    ulpiByte(bytes[3]);
    ulpiRelease();
    waitIdle();
    readBytes(bytes);
    readInfo(6'h2B, 4);
    endTest();
endtask

task automatic overflowTest();
    usbByteT     bytes[$];
    logic [31:0] stat;
    logic        err;
    startTest("overflow");
    for (int i = 0; i < fifoDepth + 3; i++) begin
        bytes.push_back(usbByteT'(i * 7 + 3));
    end
    ulpiPacket(8'h2A, bytes);
    waitIdle();
    apbRead(regStatus, stat, err);
    checkValue("dataOverflow set", 1, stat[statDataOvf]);
    bytes = bytes[0:fifoDepth-1];
    readBytes(bytes);
    readInfo(6'h2A, fifoDepth + 3);     // Dropped bytes still counted
    apbWrite(regCtrl, 32'h3, err);      // Keep readAllow, clear flags
    apbRead(regStatus, stat, err);
    checkValue("dataOverflow cleared", 0, stat[statDataOvf]);
    repeat (fifoDepth + 2) begin
        ulpiRxCmd(8'h05);
        ulpiRelease();
    end
    waitIdle();
    apbRead(regStatus, stat, err);
    checkValue("infoOverflow set", 1, stat[statInfoOvf]);
    repeat (fifoDepth) readInfo(6'h05, 0);
    apbWrite(regCtrl, 32'h3, err);
    apbRead(regStatus, stat, err);
    checkValue("infoOverflow cleared", 0, stat[statInfoOvf]);
    endTest();
endtask

task automatic randomPacketTest();
    usbByteT all[$];
    usbByteT pkt[$];
    int      lens[3];
    startTest("randomPackets");
    foreach (lens[p]) begin
        lens[p] = $urandom_range(5, 1);
        pkt.delete();
        repeat (lens[p]) pkt.push_back(usbByteT'($urandom));
        all = {all, pkt};
        ulpiPacket(usbByteT'(8'h10 + p), pkt);
    end
    waitIdle();
    foreach (lens[p]) begin
        readInfo(6'(8'h10 + p), lens[p]);
    end
    readBytes(all);
    endTest();
endtask

/* verification/ulpiRxTb.sv */
`timescale 1ns/1ps

module ulpiRxTb;

    import ulpiRxPkg::*;

    // Watchdog budget from the data bytes of all tests
    localparam int totalBytes     = 3 + 5 + 4 + (fifoDepth + 3) + 15;
    localparam int watchdogCycles = totalBytes * 20 + 2000;

    logic        clkUlpi;
    logic        rst;
    logic        dir;
    logic        nxt;
    usbByteT     dataI;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    string       testName;
    int          testErrors;
    int          totalErrors;
    int          testsRun;
    int          testsFailed;

    ulpiRxTop u_dut (
        .clkUlpi (clkUlpi),
        .rst     (rst),
        .dir     (dir),
        .nxt     (nxt),
        .dataI   (dataI),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #4 clkUlpi = ~clkUlpi;

    // One APB transfer with setup and access phases
    task automatic apbAccess(input logic write, input logic [3:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
        @(posedge clkUlpi);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clkUlpi);
        penable <= 1'b1;
        @(negedge clkUlpi);     // Mid access phase
        checkValue("pready in access phase", 1, pready);    // No wait states
        rdata = prdata;
        err   = pslverr;
        @(posedge clkUlpi);     // End of the access phase where pops land
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apbAccess(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data, output logic err);
        apbAccess(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic ulpiRxCmd(input usbByteT cmd);
        @(posedge clkUlpi);
        dir   <= 1'b1;
        nxt   <= 1'b0;
        dataI <= cmd;
    endtask

    task automatic ulpiByte(input usbByteT b);
        @(posedge clkUlpi);
        dir   <= 1'b1;
        nxt   <= 1'b1;
        dataI <= b;
    endtask

    // Turnaround back to the link
    task automatic ulpiRelease();
        @(posedge clkUlpi);
        dir <= 1'b0;
        nxt <= 1'b0;
    endtask

    task automatic ulpiPacket(input usbByteT cmd, input usbByteT bytes[$]);
        ulpiRxCmd(cmd);
        foreach (bytes[i]) begin
            ulpiByte(bytes[i]);
        end
        ulpiRelease();
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("FAIL %s %s: expected 0x%0h actual 0x%0h",
                     testName, what, expected, actual);
            testErrors++;
        end
    endtask

    // Polls status until the receiver has closed its burst
    task automatic waitIdle();
        logic [31:0] stat;
        logic        err;
        int          tries = 0;
        do begin
            apbRead(regStatus, stat, err);
            tries++;
        end while (stat[statBusy] && tries < 50);
        assert (!stat[statBusy]) else begin
            $display("Test %s: receiver still busy after %0d status reads", testName, tries);
            testErrors++;
        end
    endtask

    task automatic readBytes(input usbByteT expected[$]);
        logic [31:0] rd;
        logic        err;
        foreach (expected[i]) begin
            apbRead(regData, rd, err);
            checkValue($sformatf("data byte %0d", i), {24'b0, expected[i]}, rd);
            checkValue("pslverr on data read", 0, err);
        end
    endtask

    // Info word is rxEvent in 15:10 and byteCount in 9:0
    task automatic readInfo(input logic [5:0] ev, input int cnt);
        logic [31:0] rd;
        logic        err;
        apbRead(regInfo, rd, err);
        checkValue("info word", {16'b0, ev, cnt[9:0]}, rd);
        checkValue("pslverr on info read", 0, err);
    endtask

    // Low status half from the ULPI RX command meaning
    function automatic logic [15:0] cmdStatus(input usbByteT cmd);
        logic [15:0] s;
        s        = '0;
        s[7:0]   = cmd;
        s[9:8]   = cmd[1:0];                // LineState
        s[11:10] = cmd[3:2];                // VbusState
        s[12]    = cmd[4];
        s[13]    = cmd[5] && cmd[4];        // RxError
        s[14]    = cmd[5] && !cmd[4];       // Host disconnect
        s[15]    = cmd[6];
        return s;
    endfunction

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
        testsRun++;
    endtask

    task automatic endTest();
        if (testErrors == 0) begin
            $display("Test %s: passed", testName);
        end else begin
            $display("Test %s: failed with %0d errors", testName, testErrors);
            testsFailed++;
            totalErrors += testErrors;
        end
    endtask

    `include "ulpiRxTests.svh"

    initial begin
        clkUlpi     = 1'b0;
        rst         = 1'b0;
        dir         = 1'b0;
        nxt         = 1'b0;
        dataI       = '0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        totalErrors = 0;
        testsRun    = 0;
        testsFailed = 0;
        void'($urandom(39));
        repeat (10) @(posedge clkUlpi);
        rst <= 1'b1;
        afterResetTest();
        singlePacketTest();
        rxCmdOnlyTest();
        cmdInPacketTest();
        overflowTest();
        randomPacketTest();
        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, totalErrors);
        if (totalErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clkUlpi);
        $display("Watchdog expired after %0d cycles, the run hung", watchdogCycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* files.f */
+incdir+verification
verilog/ulpiRxPkg.sv
verilog/rxFifoIf.sv
verilog/ulpiRecv.sv
verilog/rxFifo.sv
verilog/apbRxRegs.sv
verilog/ulpiRxTop.sv
verification/ulpiRxTb.sv
